/* tb/mem_input.txt */
# Columns: op (W write, R read), byte mode, address, write data, expected read (hex)
# Expected value is only checked on R lines, one bus operation per clock
W 0 0200 1234 0000
W 0 05FE ABCD 0000
W 0 4400 5A5A 0000
W 0 C3FE 0F0F 0000
W 0 FF80 8001 0000
W 0 FFFE FFFE 0000
R 0 0200 0000 1234
R 0 05FE 0000 ABCD
R 0 4400 0000 5A5A
R 0 C3FE 0000 0F0F
R 0 FF80 0000 8001
R 0 FFFE 0000 FFFE
W 0 0300 1111 0000
W 1 0301 00A5 0000
W 1 0300 003C 0000
R 0 0300 0000 A53C
R 1 0301 0000 00A5
R 1 0300 0000 003C
W 0 8000 2222 0000
W 1 8001 0077 0000
R 0 8000 0000 7722
R 1 8000 0000 0022
R 0 0200 DEAD 1234
R 0 0200 0000 1234
W 0 0100 BEEF 0000
W 0 C400 BEEF 0000
R 0 0200 0000 1234
R 0 C3FE 0000 0F0F
R 0 0100 0000 0000
R 0 C400 0000 0000
R 1 C401 0000 0000
W 0 0400 C0DE 0000
R 0 0400 0000 C0DE
W 0 FF82 0000 0000
W 1 FF83 0099 0000
R 0 FF82 0000 9900
W 0 6000 1357 0000
R 1 6001 0000 0013

/* flist.f */
+incdir+common
common/mem_pkg.sv
hw/blockMemory.sv
memBus/busDecoder.sv
memBus/readAligner.sv
memBus/blockMemInterface.sv
tb/blockMemInterface_sva.sv
tb/blockMemInterface_tb.sv

/* Bender.yml */
package:
  name: block_mem_interface

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - hw/blockMemory.sv
      - memBus/busDecoder.sv
      - memBus/readAligner.sv
      - memBus/blockMemInterface.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/blockMemInterface_sva.sv
      - tb/blockMemInterface_tb.sv

/* tb/blockMemInterface_tb.sv */
// Testbench for the memory bus top level, replays tb/mem_input.txt and checks every read result
module blockMemInterface_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxCycles = 1000;

    logic        MCLK;
    logic        reset;
    logic [15:0] mab;
    logic [15:0] mdbWrite;
    logic        mw;
    logic        bw;
    logic [15:0] mdbRead;

    integer      fd;
    integer      lineLen;
    integer      fields;
    integer      cycleCount;
    integer      readCount;
    string       line;
    logic [7:0]  op;
    logic [15:0] bwFlag;
    logic [15:0] addr;
    logic [15:0] wdata;
    logic [15:0] expected;
    logic        pendingRead;
    logic [15:0] pendingAddr;
    logic [15:0] pendingExp;

    blockMemInterface dut0 (
        .MCLK    (MCLK),
        .reset   (reset),
        .mab     (mab),
        .mdbWrite(mdbWrite),
        .mw      (mw),
        .bw      (bw),
        .mdbRead (mdbRead)
    );

    initial begin
        MCLK = 1'b0;
        forever #50 MCLK = ~MCLK;  // 100 ns period
    end

    task automatic stopWithFailure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Compares the read bus with the value from the vector file
    task automatic checkRead(input logic [15:0] rdAddr, input logic [15:0] rdExp);
        assert (mdbRead === rdExp) else begin
            $display("Mismatch at %0t ns: read of %h returned %h, expected %h",
                     $time, rdAddr, mdbRead, rdExp);
            stopWithFailure();
        end
    endtask

    initial begin
        mab         = 16'h0000;
        mdbWrite    = 16'h0000;
        mw          = 1'b0;
        bw          = 1'b0;
        reset       = 1'b1;
        cycleCount  = 0;
        readCount   = 0;
        pendingRead = 1'b0;
        pendingAddr = 16'h0000;
        pendingExp  = 16'h0000;

        fd = $fopen("tb/mem_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file tb/mem_input.txt");
            stopWithFailure();
        end

        repeat (5) @(posedge MCLK);
        reset <= 1'b0;
        @(negedge MCLK);
        checkRead(16'h0000, 16'h0000);  // Aligner starts at regionNone

        while (!$feof(fd)) begin
            lineLen = $fgets(line, fd);
            if (lineLen > 1 && line.substr(0, 0) != "#") begin
                fields = $sscanf(line, "%c %h %h %h %h", op, bwFlag, addr, wdata, expected);
                if (fields != 5 || (op != "W" && op != "R")) begin
                    $display("Vector line could not be parsed: %s", line);
                    stopWithFailure();
                end
                @(posedge MCLK);
                cycleCount = cycleCount + 1;
                if (cycleCount > MaxCycles) begin
                    $display("Vector loop ran past %0d cycles without finishing", MaxCycles);
                    stopWithFailure();
                end
                mab      <= addr;
                mdbWrite <= wdata;
                mw       <= (op == "W");
                bw       <= bwFlag[0];
                // Result of the previous read is on the bus now
                @(negedge MCLK);
                if (pendingRead) begin
                    checkRead(pendingAddr, pendingExp);
                end
                pendingRead = (op == "R");
                pendingAddr = addr;
                pendingExp  = expected;
                if (op == "R") begin
                    readCount = readCount + 1;
                end
            end
        end
        $fclose(fd);

        // Flush the last read
        @(posedge MCLK);
        mab <= 16'h0000;
        mw  <= 1'b0;
        bw  <= 1'b0;
        @(negedge MCLK);
        if (pendingRead) begin
            checkRead(pendingAddr, pendingExp);
        end

        if (readCount == 0) begin
            $display("No read vectors were found in the vector file");
            stopWithFailure();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* tb/blockMemInterface_sva.sv */
// Bound checker for the memory bus top level, asserts write-enable rules and reset read value
module blockMemInterface_sva (
    input logic        MCLK,
    input logic        reset,
    input logic        mw,
    input logic        bw,
    input logic [1:0]  ramWe,
    input logic [1:0]  framWe,
    input logic [1:0]  ivtWe,
    input logic [15:0] mdbRead
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0] anyWe;

    assign anyWe = ramWe | framWe | ivtWe;  // Lanes over all ports

    // Only the decoded region may write
    onePortWrites: assert property (
        @(posedge MCLK) disable iff (reset) $onehot0({|ramWe, |framWe, |ivtWe})
    ) else $error("More than one memory port has a write enable set");

    weNeedsMw: assert property (
        @(posedge MCLK) disable iff (reset) (|anyWe) |-> mw
    ) else $error("Write enable set while mw is low");

    // A byte write touches a single lane
    byteWeOneHot: assert property (
        @(posedge MCLK) disable iff (reset) (bw && |anyWe) |-> $onehot(anyWe)
    ) else $error("Byte write enables more than one lane");

    readZeroAfterReset: assert property (
        @(posedge MCLK) reset |=> (mdbRead == 16'h0000)
    ) else $error("mdbRead is not zero in the cycle after reset");

endmodule

bind blockMemInterface blockMemInterface_sva sva0 (
    .MCLK   (MCLK),
    .reset  (reset),
    .mw     (mw),
    .bw     (bw),
    .ramWe  (ramPort.we),
    .framWe (framPort.we),
    .ivtWe  (ivtPort.we),
    .mdbRead(mdbRead)
);

/* memBus/blockMemInterface.sv */
// Memory side of the system bus, connecting decoder, RAM, FRAM and IVT memories and read aligner
`include "mem_consts.svh"

module blockMemInterface (
    input  logic        MCLK,
    input  logic        reset,
    input  logic [15:0] mab,
    input  logic [15:0] mdbWrite,
    input  logic        mw,
    input  logic        bw,
    output logic [15:0] mdbRead
);

    memPkg::busReq    req;
    memPkg::memPort   ramPort;
    memPkg::memPort   framPort;
    memPkg::memPort   ivtPort;
    memPkg::memRegion sel;
    logic [15:0]      ramDout;
    logic [15:0]      framDout;
    logic [15:0]      ivtDout;

    assign req = '{addr: mab, wdata: mdbWrite, write: mw, byteMode: bw};

    busDecoder decoder (
        .req     (req),
        .ramPort (ramPort),
        .framPort(framPort),
        .ivtPort (ivtPort),
        .sel     (sel)
    );

    blockMemory #(.AddrWidth(`RAM_AW)) ramMem (
        .MCLK(MCLK), .port(ramPort), .dout(ramDout)
    );

    blockMemory #(.AddrWidth(`FRAM_AW)) framMem (
        .MCLK(MCLK), .port(framPort), .dout(framDout)
    );

    blockMemory #(.AddrWidth(`IVT_AW)) ivtMem (
        .MCLK(MCLK), .port(ivtPort), .dout(ivtDout)
    );

    readAligner aligner (
        .MCLK    (MCLK),
        .reset   (reset),
        .sel     (sel),
        .byteMode(req.byteMode),
        .highByte(req.addr[0]),  // Odd address reads the high lane
        .ramData (ramDout),
        .framData(framDout),
        .ivtData (ivtDout),
        .mdbRead (mdbRead)
    );

endmodule

/* memBus/readAligner.sv */
// Read-bus alignment: delays region and lane select to the memory latency and forms mdbRead
module readAligner (
    input  logic             MCLK,
    input  logic             reset,
    input  memPkg::memRegion sel,
    input  logic             byteMode,
    input  logic             highByte,
    input  logic [15:0]      ramData,
    input  logic [15:0]      framData,
    input  logic [15:0]      ivtData,
    output logic [15:0]      mdbRead
);

    memPkg::memRegion selQ;
    logic             byteModeQ;
    logic             highByteQ;
    logic [15:0]      word;

    // Same edge as the memory read
    always_ff @(posedge MCLK) begin
        if (reset) begin
            selQ      <= memPkg::regionNone;
            byteModeQ <= 1'b0;
            highByteQ <= 1'b0;
        end else begin
            selQ      <= sel;
            byteModeQ <= byteMode;
            highByteQ <= highByte;
        end
    end

    // Unmapped reads return zero
    always_comb begin
        case (selQ)
            memPkg::regionRam:  word = ramData;
            memPkg::regionFram: word = framData;
            memPkg::regionIvt:  word = ivtData;
            default:            word = 16'h0000;
        endcase
    end

    // Byte reads are zero-extended
    always_comb begin
        if (byteModeQ && highByteQ) begin
            mdbRead = {8'h00, word[15:8]};
        end else if (byteModeQ) begin
            mdbRead = {8'h00, word[7:0]};
        end else begin
            mdbRead = word;
        end
    end

endmodule

/* memBus/busDecoder.sv */
// Combinational address decode and byte-lane steering from the bus into the three memory ports
`include "mem_consts.svh"

module busDecoder (
    input  memPkg::busReq    req,
    output memPkg::memPort   ramPort,
    output memPkg::memPort   framPort,
    output memPkg::memPort   ivtPort,
    output memPkg::memRegion sel
);

    logic        inRam;
    logic        inFram;
    logic        inIvt;
    logic [1:0]  laneWe;
    logic [15:0] laneDin;

    // Builds the port for one region, all zero when the region is not hit
    function automatic memPkg::memPort makePort(
        input logic        hit,
        input logic [15:0] addr,
        input logic [15:0] base,
        input logic [1:0]  we,
        input logic [15:0] din
    );
        logic [15:0] offset;
        offset = {addr[15:1], 1'b0} - base;
        makePort = '0;
        if (hit) begin
            makePort.we       = we;
            makePort.wordAddr = offset[15:1];  // Byte offset to word offset
            makePort.din      = din;
        end
    endfunction

    assign inRam  = (req.addr >= `RAM_START) && (req.addr < `RAM_START + `RAM_LEN);
    assign inFram = (req.addr >= `FRAM_START) && (req.addr < `FRAM_START + `FRAM_LEN);
    assign inIvt  = (req.addr >= `IVT_START);  // Up to top of address space

    always_comb begin
        sel = memPkg::regionNone;
        if (inRam) begin
            sel = memPkg::regionRam;
        end else if (inFram) begin
            sel = memPkg::regionFram;
        end else if (inIvt) begin
            sel = memPkg::regionIvt;
        end
    end

    // Lane steering by byte mode and address bit 0
    always_comb begin
        if (req.byteMode && req.addr[0]) begin
            laneDin = {req.wdata[7:0], 8'h00};  // Odd byte goes high
            laneWe  = 2'b10;
        end else if (req.byteMode) begin
            laneDin = {8'h00, req.wdata[7:0]};
            laneWe  = 2'b01;
        end else begin
            laneDin = req.wdata;
            laneWe  = 2'b11;
        end
        if (!req.write) begin
            laneWe = 2'b00;  // Read cycle
        end
    end

    assign ramPort  = makePort(inRam, req.addr, `RAM_START, laneWe, laneDin);
    assign framPort = makePort(inFram, req.addr, `FRAM_START, laneWe, laneDin);
    assign ivtPort  = makePort(inIvt, req.addr, `IVT_START, laneWe, laneDin);

endmodule

/* hw/blockMemory.sv */
// Byte-writable word memory with read-first output that the top level uses for each region
module blockMemory #(
    parameter int unsigned AddrWidth = 9
) (
    input  logic           MCLK,
    input  memPkg::memPort port,
    output logic [15:0]    dout
);

    localparam int unsigned Depth = 1 << AddrWidth;

    logic [15:0]          mem [Depth];
    logic [AddrWidth-1:0] addr;

    // Only the low bits matter for this instance
    assign addr = port.wordAddr[AddrWidth-1:0];

    // Each lane has its own enable
    always_ff @(posedge MCLK) begin
        if (port.we[0]) begin
            mem[addr][7:0] <= port.din[7:0];  // Low lane
        end
        if (port.we[1]) begin
            mem[addr][15:8] <= port.din[15:8];  // High lane
        end
    end

    // Read-first so that a write cycle returns the old word
    always_ff @(posedge MCLK) begin
        dout <= mem[addr];
    end

endmodule

/* common/mem_pkg.sv */
// Shared types for the memory bus: region select, bus request and memory port structs
`include "mem_consts.svh"

package memPkg;

    // Region hit by the current bus address
    typedef enum logic [1:0] {
        regionNone,
        regionRam,
        regionFram,
        regionIvt
    } memRegion;

    // One bus cycle as seen by the memory side
    typedef struct packed {
        logic [15:0]         addr;      // MAB, byte address
        logic [`MEM_DW-1:0]  wdata;     // MDBwrite
        logic                write;     // MW level
        logic                byteMode;  // BW
    } busReq;

    // Request for one block memory
    typedef struct packed {
        logic [1:0]          we;        // Bit 1 is the high lane
        logic [`PORT_AW-1:0] wordAddr;  // Offset within region
        logic [`MEM_DW-1:0]  din;
    } memPort;

endpackage

/* common/mem_consts.svh */
// Memory map and width macros for the system memory bus, included by the package and RTL
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Bus data width and the port-side word address width
`define MEM_DW   16
`define PORT_AW  15

// RAM region, 1 KiB
`define RAM_START   16'h0200
`define RAM_LEN     16'h0400

// FRAM region, 32 KiB
`define FRAM_START  16'h4400
`define FRAM_LEN    16'h8000

// Interrupt vector table, runs up to 16'hFFFF
`define IVT_START   16'hFF80

// Word address widths per region
`define RAM_AW   9   // 512 words
`define FRAM_AW  14  // 16K words
`define IVT_AW   6   // 64 words

`endif
